/* Makefile */
# Verilator simulation of tb_dsp_readout, pass decided from the log

sim:
	verilator --binary --timing --assert -j 0 --top-module tb_dsp_readout \
		-f dsp_readout.f -o sim_tb
	./obj_dir/sim_tb | tee sim.log
	grep -qF "*** TEST PASSED ***" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean

/* design/acc_buf_writer.sv */
// ----------------------------------------------------------------------
// accumulation buffer writer
// write strobe, address counter locking at the last entry, write data
// and the sign of each result as a one-bit measurement
// ----------------------------------------------------------------------
`timescale 1ns/1ps

module acc_buf_writer #(
	parameter int ACC_W  = readout_pkg::ACC_W,
	parameter int ADDR_W = readout_pkg::ADDR_W
) (
	input  logic                     dspif,
	input  logic                     rst_n,
	input  logic                     acc_clear,
	input  logic signed [ACC_W-1:0]  result,
	input  logic                     result_stb,
	output logic                     buf_we,
	output logic [ADDR_W-1:0]        buf_addr,
	output logic signed [ACC_W-1:0]  buf_data,
	output logic                     meas,
	output logic                     meas_valid
);
	import readout_pkg::*;

	// registered write word
	acc_t data_q;
	// address is all ones, stop counting
	logic lock_last;

	assign lock_last = &buf_addr;
	assign buf_data  = data_q;

	always_ff @(posedge dspif or negedge rst_n) begin
		if (!rst_n) begin
			buf_we     <= 1'b0;
			meas_valid <= 1'b0;
			buf_addr   <= '0;
		end else begin
			buf_we     <= result_stb;
			meas_valid <= buf_we;
			// clear beats a write in the same cycle
			if (acc_clear) begin
				buf_addr <= '0;
			end else if (buf_we && !lock_last) begin
				buf_addr <= buf_addr + 1'b1;
			end
		end
	end

	// payload registers
	always_ff @(posedge dspif) begin
		if (result_stb) begin
			data_q <= result;
		end
		// threshold at zero, negative gives 1
		if (buf_we) begin
			meas <= data_q[ACC_W-1];
		end
	end

endmodule

/* design/baseband_select.sv */
// ----------------------------------------------------------------------
// baseband source select
// picks ADC, DAC lane 0 monitor or zero per channel and registers it
// together with the channel gate
// ----------------------------------------------------------------------
`timescale 1ns/1ps

module baseband_select #(
	parameter int NCHAN    = readout_pkg::NCHAN,
	parameter int SAMPLE_W = readout_pkg::SAMPLE_W
) (
	input  logic                                        dspif,
	input  logic                                        rst_n,
	input  logic signed [SAMPLE_W-1:0]                  adc,
	input  logic [readout_pkg::DAC_LANES*SAMPLE_W-1:0]  dac0,
	input  logic [readout_pkg::DAC_LANES*SAMPLE_W-1:0]  dac1,
	input  seq_pkg::src_sel_t                           src_sel [NCHAN],
	input  logic [NCHAN-1:0]                            gate,
	output logic signed [SAMPLE_W-1:0]                  sample [NCHAN],
	output logic [NCHAN-1:0]                            sample_gate
);
	import readout_pkg::*;
	import seq_pkg::*;

	// undersampled DAC monitor values
	sample_t dac0_lane0;
	sample_t dac1_lane0;
	// selected value per channel ahead of the register
	sample_t sel_val [NCHAN];

	// only lane 0 of each word is watched
	assign dac0_lane0 = dac0[SAMPLE_W-1:0];
	assign dac1_lane0 = dac1[SAMPLE_W-1:0];

	always_comb begin
		for (int i = 0; i < NCHAN; i++) begin
			case (src_sel[i])
				SRC_ADC:  sel_val[i] = adc;
				SRC_DAC0: sel_val[i] = dac0_lane0;
				SRC_DAC1: sel_val[i] = dac1_lane0;
				SRC_ZERO: sel_val[i] = '0;
			endcase
		end
	end

	// selected sample register
	always_ff @(posedge dspif) begin
		for (int i = 0; i < NCHAN; i++) begin
			sample[i] <= sel_val[i];
		end
	end

	// gate goes through the same single stage
	// so it still lines up with its sample
	always_ff @(posedge dspif or negedge rst_n) begin
		if (!rst_n) begin
			sample_gate <= '0;
		end else begin
			sample_gate <= gate;
		end
	end

endmodule

/* design/dsp_readout.sv */
// ----------------------------------------------------------------------
// readout and shot-control top level
// source select, per-channel integrator and buffer writer, sequencer
// ----------------------------------------------------------------------
`timescale 1ns/1ps

module dsp_readout #(
	parameter int NCHAN    = readout_pkg::NCHAN,
	parameter int SAMPLE_W = readout_pkg::SAMPLE_W,
	parameter int ACC_W    = readout_pkg::ACC_W,
	parameter int ADDR_W   = readout_pkg::ADDR_W
) (
	input  logic                                dspif,
	input  logic                                rst_n,
	input  logic signed [SAMPLE_W-1:0]          adc,
	input  logic [readout_pkg::DAC_W-1:0]       dac0,
	input  logic [readout_pkg::DAC_W-1:0]       dac1,
	input  seq_pkg::src_sel_t                   src_sel [NCHAN],
	input  logic [NCHAN-1:0]                    gate,
	input  logic [readout_pkg::SHIFT_W-1:0]     shift,
	input  logic                                acc_clear,
	input  logic                                stb_start,
	input  logic [seq_pkg::SHOT_W-1:0]          nshot,
	input  logic                                core_done,
	input  logic                                elem_idle,
	output logic [NCHAN-1:0]                    buf_we,
	output logic [ADDR_W-1:0]                   buf_addr [NCHAN],
	output logic signed [ACC_W-1:0]             buf_data [NCHAN],
	output logic [NCHAN-1:0]                    meas,
	output logic [NCHAN-1:0]                    meas_valid,
	output logic                                proc_reset,
	output logic                                proc_done,
	output logic [seq_pkg::SHOT_W-1:0]          shot_cnt,
	output logic                                last_shot_done
);
	// selected sample and gate, one cycle behind the inputs
	logic signed [SAMPLE_W-1:0] sample [NCHAN];
	logic [NCHAN-1:0]           sample_gate;
	// dumped window sums
	logic signed [ACC_W-1:0]    result [NCHAN];
	logic [NCHAN-1:0]           result_stb;

	baseband_select #(
		.NCHAN    (NCHAN),
		.SAMPLE_W (SAMPLE_W)
	) i_baseband_select (
		.dspif       (dspif),
		.rst_n       (rst_n),
		.adc         (adc),
		.dac0        (dac0),
		.dac1        (dac1),
		.src_sel     (src_sel),
		.gate        (gate),
		.sample      (sample),
		.sample_gate (sample_gate)
	);

	// one integrator and buffer writer per channel
	for (genvar i = 0; i < NCHAN; i++) begin : g_chan
		integrate_dump #(
			.SAMPLE_W (SAMPLE_W),
			.ACC_W    (ACC_W)
		) i_integrate_dump (
			.dspif       (dspif),
			.rst_n       (rst_n),
			.sample      (sample[i]),
			.sample_gate (sample_gate[i]),
			.shift       (shift),
			.result      (result[i]),
			.result_stb  (result_stb[i])
		);

		acc_buf_writer #(
			.ACC_W  (ACC_W),
			.ADDR_W (ADDR_W)
		) i_acc_buf_writer (
			.dspif      (dspif),
			.rst_n      (rst_n),
			.acc_clear  (acc_clear),
			.result     (result[i]),
			.result_stb (result_stb[i]),
			.buf_we     (buf_we[i]),
			.buf_addr   (buf_addr[i]),
			.buf_data   (buf_data[i]),
			.meas       (meas[i]),
			.meas_valid (meas_valid[i])
		);
	end

	// runs beside the datapath, no shared signals
	shot_sequencer i_shot_sequencer (
		.dspif          (dspif),
		.rst_n          (rst_n),
		.stb_start      (stb_start),
		.nshot          (nshot),
		.core_done      (core_done),
		.elem_idle      (elem_idle),
		.proc_reset     (proc_reset),
		.proc_done      (proc_done),
		.shot_cnt       (shot_cnt),
		.last_shot_done (last_shot_done)
	);

endmodule

/* design/integrate_dump.sv */
// ----------------------------------------------------------------------
// gated integrator
// sums sign-extended samples while the gate is high, dumps the sum
// shifted right arithmetically with a one-cycle strobe on gate close
// ----------------------------------------------------------------------
`timescale 1ns/1ps

module integrate_dump #(
	parameter int SAMPLE_W = readout_pkg::SAMPLE_W,
	parameter int ACC_W    = readout_pkg::ACC_W
) (
	input  logic                               dspif,
	input  logic                               rst_n,
	input  logic signed [SAMPLE_W-1:0]         sample,
	input  logic                               sample_gate,
	input  logic [readout_pkg::SHIFT_W-1:0]    shift,
	output readout_pkg::acc_t                  result,
	output logic                               result_stb
);
	import readout_pkg::*;

	// running sum of the open window
	logic signed [ACC_W-1:0] sum;
	// sample widened to the sum
	logic signed [ACC_W-1:0] sample_ext;
	// gate of the previous cycle
	logic gate_d;
	// first low cycle after a high window
	logic gate_close;
	// scaled value handed out on close
	acc_t dump_val;

	assign sample_ext = {{(ACC_W-SAMPLE_W){sample[SAMPLE_W-1]}}, sample};
	assign gate_close = gate_d & ~sample_gate;

	// arithmetic shift keeps the sign of negative sums
	assign dump_val = acc_t'(sum >>> shift);

	always_ff @(posedge dspif or negedge rst_n) begin
		if (!rst_n) begin
			gate_d     <= 1'b0;
			result_stb <= 1'b0;
			sum        <= '0;
		end else begin
			gate_d     <= sample_gate;
			result_stb <= gate_close;
			if (sample_gate) begin
				sum <= sum + sample_ext;
			end else if (gate_close) begin
				// restart from zero for the next window
				sum <= '0;
			end
		end
	end

	// result is only meaningful with result_stb
	always_ff @(posedge dspif) begin
		if (gate_close) begin
			result <= dump_val;
		end
	end

endmodule

/* design/readout_pkg.sv */
// ----------------------------------------------------------------------
// readout datapath formats
// channel count, sample and DAC word widths, accumulator and buffer
// address widths, dump shift width, signed sample and accumulator types
// ----------------------------------------------------------------------
package readout_pkg;

	// two independent readout channels
	localparam int NCHAN = 2;

	// ADC sample and one DAC lane share a width
	localparam int SAMPLE_W = 16;

	// lanes packed into each DAC word
	localparam int DAC_LANES = 4;

	// full DAC word, lane 0 in the low bits
	localparam int DAC_W = DAC_LANES * SAMPLE_W;

	// integrator sum and buffer word
	localparam int ACC_W = 32;

	// accumulation buffer depth is 2**ADDR_W
	localparam int ADDR_W = 4;

	// right shift applied at dump
	localparam int SHIFT_W = 5;

	// one baseband sample, two's complement
	typedef logic signed [SAMPLE_W-1:0] sample_t;

	// integrator result as written to the buffer
	typedef logic signed [ACC_W-1:0] acc_t;

endpackage

/* design/seq_pkg.sv */
// ----------------------------------------------------------------------
// control encodings
// shot count width, sequencer state codes, baseband source codes
// ----------------------------------------------------------------------
package seq_pkg;

	// shot counter and nshot width
	localparam int SHOT_W = 32;

	// sequencer states
	// neighbouring states differ in one bit where possible
	typedef enum logic [3:0] {
		S_IDLE      = 4'b0000,
		S_START     = 4'b0001,
		S_PROC_RUN  = 4'b0011,
		S_ELEM_BUSY = 4'b0010,
		S_MORE_SHOT = 4'b0110,
		S_SHOT_ADD  = 4'b0111,
		S_DONE      = 4'b0101
	} seq_state_t;

	// per-channel baseband source
	typedef enum logic [1:0] {
		SRC_ADC  = 2'd0,
		SRC_DAC0 = 2'd1,
		SRC_DAC1 = 2'd2,
		SRC_ZERO = 2'd3
	} src_sel_t;

endpackage

/* design/shot_sequencer.sv */
// ----------------------------------------------------------------------
// shot sequencer
// repeats the processor run nshot times, endless when nshot is zero
// core reset between shots, shot count, done flag, last-shot strobe
// ----------------------------------------------------------------------
`timescale 1ns/1ps

module shot_sequencer (
	input  logic                        dspif,
	input  logic                        rst_n,
	input  logic                        stb_start,
	input  logic [seq_pkg::SHOT_W-1:0]  nshot,
	input  logic                        core_done,
	input  logic                        elem_idle,
	output logic                        proc_reset,
	output logic                        proc_done,
	output logic [seq_pkg::SHOT_W-1:0]  shot_cnt,
	output logic                        last_shot_done
);
	import seq_pkg::*;

	seq_state_t state;
	seq_state_t next_state;

	// shot target, held for the whole run
	logic [SHOT_W-1:0] nshot_q;
	// count once the current shot is finished
	logic [SHOT_W-1:0] next_cnt;
	// core status, one register stage
	logic core_done_r;
	logic elem_idle_r;
	// another shot is needed
	logic more_shot;

	assign next_cnt = shot_cnt + 1'b1;

	// zero target never matches, so the run never ends
	assign more_shot = (next_cnt != nshot_q) || (nshot_q == '0);

	always_ff @(posedge dspif or negedge rst_n) begin
		if (!rst_n) begin
			state <= S_IDLE;
		end else begin
			state <= next_state;
		end
	end

	always_comb begin
		next_state = state;
		case (state)
			S_IDLE: begin
				if (stb_start) begin
					next_state = S_START;
				end
			end
			S_START: begin
				next_state = S_PROC_RUN;
			end
			// cores running, wait for done
			S_PROC_RUN: begin
				if (core_done_r) begin
					next_state = S_ELEM_BUSY;
				end
			end
			// cores held in reset, wait for elements to drain
			S_ELEM_BUSY: begin
				if (elem_idle_r) begin
					next_state = S_MORE_SHOT;
				end
			end
			S_MORE_SHOT: begin
				next_state = more_shot ? S_SHOT_ADD : S_DONE;
			end
			S_SHOT_ADD: begin
				next_state = S_START;
			end
			S_DONE: begin
				next_state = S_IDLE;
			end
			default: begin
				next_state = S_IDLE;
			end
		endcase
	end

	// outputs registered from the next state
	always_ff @(posedge dspif or negedge rst_n) begin
		if (!rst_n) begin
			core_done_r    <= 1'b0;
			elem_idle_r    <= 1'b0;
			proc_reset     <= 1'b1;
			last_shot_done <= 1'b0;
			nshot_q        <= '0;
			shot_cnt       <= '0;
		end else begin
			core_done_r    <= core_done;
			elem_idle_r    <= elem_idle;
			// cores only leave reset in start and proc_run
			proc_reset     <= !(next_state == S_START || next_state == S_PROC_RUN);
			last_shot_done <= (next_state == S_DONE);
			if (state == S_IDLE && stb_start) begin
				// new run, count restarts
				nshot_q  <= nshot;
				shot_cnt <= '0;
			end else if (next_state == S_SHOT_ADD) begin
				// completed shots so far
				shot_cnt <= next_cnt;
			end
		end
	end

	// set by core done, dropped as the next shot starts
	always_ff @(posedge dspif or negedge rst_n) begin
		if (!rst_n) begin
			proc_done <= 1'b0;
		end else if (core_done_r) begin
			proc_done <= 1'b1;
		end else if (state == S_START) begin
			proc_done <= 1'b0;
		end
	end

endmodule

/* dsp_readout.f */
design/readout_pkg.sv
design/seq_pkg.sv
design/baseband_select.sv
design/integrate_dump.sv
design/acc_buf_writer.sv
design/shot_sequencer.sv
design/dsp_readout.sv
tb/dsp_readout_sva.sv
tb/tb_dsp_readout.sv

/* tb/dsp_readout_sva.sv */
// ----------------------------------------------------------------------
// bound assertions on the readout top level
// single-cycle buffer writes, buffer address never moving back on its
// own, last-shot strobe only while the cores are held in reset
// ----------------------------------------------------------------------
`timescale 1ns/1ps

module dsp_readout_sva #(
	parameter int NCHAN  = readout_pkg::NCHAN,
	parameter int ADDR_W = readout_pkg::ADDR_W
) (
	input logic              dspif,
	input logic              rst_n,
	input logic              acc_clear,
	input logic [NCHAN-1:0]  buf_we,
	input logic [ADDR_W-1:0] buf_addr [NCHAN],
	input logic              proc_reset,
	input logic              last_shot_done
);
	for (genvar i = 0; i < NCHAN; i++) begin : g_chan
		// one write per dumped window
		a_we_pulse: assert property (
			@(posedge dspif) disable iff (!rst_n) buf_we[i] |=> !buf_we[i]
		) else $error("buf_we[%0d] high in two consecutive cycles", i);

		// only acc_clear moves the address back
		a_addr_up: assert property (
			@(posedge dspif) disable iff (!rst_n)
			!$past(acc_clear) |-> buf_addr[i] >= $past(buf_addr[i])
		) else $error("buf_addr[%0d] went down without acc_clear", i);
	end

	// run end only reported with cores in reset
	a_last_in_reset: assert property (
		@(posedge dspif) disable iff (!rst_n) last_shot_done |-> proc_reset
	) else $error("last_shot_done while proc_reset is low");

endmodule

/* tb/dsp_readout_tests.txt */
# W mask src0 src1 shift rep a0 a1 a2 a3 b0 b1 b2 b3 exp0 exp1 (a to ch0, b to ch1)
# C pulses acc_clear; S nshot final_shot_cnt (nshot 0 runs until that count)
C
W 1 0 3 0 1 100 200 -50 7 0 0 0 0 257 0
W 1 1 3 1 1 1000 -3000 25 5 0 0 0 0 -985 0
W 1 2 3 2 1 32767 32767 32767 32767 0 0 0 0 32767 0
W 1 3 3 0 1 9 9 9 9 0 0 0 0 0 0
W 2 3 0 0 1 0 0 0 0 1 2 3 4 0 10
W 2 3 1 0 1 0 0 0 0 -7 -7 -7 -7 0 -28
W 2 3 2 3 1 0 0 0 0 800 800 800 800 0 400
W 1 0 3 0 1 -1 -2 -3 -4 0 0 0 0 -10 0
W 1 0 3 1 1 -1 -2 -3 -4 0 0 0 0 -5 0
W 1 0 3 2 1 -1 -2 -3 -4 0 0 0 0 -3 0
W 1 0 3 3 1 -1 -2 -3 -4 0 0 0 0 -2 0
W 1 0 3 4 1 -1 -2 -3 -4 0 0 0 0 -1 0
W 1 0 3 4 1 -32768 -32768 -32768 -32768 0 0 0 0 -8192 0
W 3 1 2 1 1 500 -600 700 -800 -3 -5 -7 -9 -100 -12
W 3 0 1 0 1 11 22 33 44 -100 50 -25 10 110 -65
W 1 0 3 0 17 1 1 1 1 0 0 0 0 4 0
C
W 3 2 0 2 1 -400 -400 -400 -400 8 8 8 8 -400 8
S 3 2
S 1 0
S 0 5

/* tb/tb_dsp_readout.sv */
// ----------------------------------------------------------------------
// testbench for the readout and shot-control top level
// clock, reset, record-driven stimulus, window sum model, core model,
// value checks and watchdog
// ----------------------------------------------------------------------
`timescale 1ns/1ps

module tb_dsp_readout;
	import readout_pkg::*;
	import seq_pkg::*;

	localparam int CLK_HALF   = 10;
	// cycles allowed per record
	localparam int REC_BUDGET = 400;
	// core model delays in cycles
	localparam int CORE_WAIT  = 5;
	localparam int ELEM_WAIT  = 3;
	localparam int NFIELD     = 15;
	localparam int MAX_REC    = 64;

	logic                       dspif;
	logic                       rst_n;
	logic signed [SAMPLE_W-1:0] adc;
	logic [DAC_W-1:0]           dac0;
	logic [DAC_W-1:0]           dac1;
	src_sel_t                   src_sel [NCHAN];
	logic [NCHAN-1:0]           gate;
	logic [SHIFT_W-1:0]         shift;
	logic                       acc_clear;
	logic                       stb_start;
	logic [SHOT_W-1:0]          nshot;
	logic                       core_done;
	logic                       elem_idle;
	logic [NCHAN-1:0]           buf_we;
	logic [ADDR_W-1:0]          buf_addr [NCHAN];
	logic signed [ACC_W-1:0]    buf_data [NCHAN];
	logic [NCHAN-1:0]           meas;
	logic [NCHAN-1:0]           meas_valid;
	logic                       proc_reset;
	logic                       proc_done;
	logic [SHOT_W-1:0]          shot_cnt;
	logic                       last_shot_done;

	int  seed = 71339;
	int  n_checks;
	int  n_errors;
	int  n_rec;
	bit  loaded;
	// record letter and its numeric fields
	byte rec_kind [MAX_REC];
	int  rec_val [MAX_REC][NFIELD];
	// next buffer address per channel
	int  exp_addr [NCHAN];
	// core model counters
	int  run_cyc;
	int  idle_cyc;

	dsp_readout #(
		.NCHAN    (NCHAN),
		.SAMPLE_W (SAMPLE_W),
		.ACC_W    (ACC_W),
		.ADDR_W   (ADDR_W)
	) i_dsp_readout (
		.dspif          (dspif),
		.rst_n          (rst_n),
		.adc            (adc),
		.dac0           (dac0),
		.dac1           (dac1),
		.src_sel        (src_sel),
		.gate           (gate),
		.shift          (shift),
		.acc_clear      (acc_clear),
		.stb_start      (stb_start),
		.nshot          (nshot),
		.core_done      (core_done),
		.elem_idle      (elem_idle),
		.buf_we         (buf_we),
		.buf_addr       (buf_addr),
		.buf_data       (buf_data),
		.meas           (meas),
		.meas_valid     (meas_valid),
		.proc_reset     (proc_reset),
		.proc_done      (proc_done),
		.shot_cnt       (shot_cnt),
		.last_shot_done (last_shot_done)
	);

	bind dsp_readout dsp_readout_sva #(
		.NCHAN  (NCHAN),
		.ADDR_W (ADDR_W)
	) i_dsp_readout_sva (
		.dspif          (dspif),
		.rst_n          (rst_n),
		.acc_clear      (acc_clear),
		.buf_we         (buf_we),
		.buf_addr       (buf_addr),
		.proc_reset     (proc_reset),
		.last_shot_done (last_shot_done)
	);

	always #CLK_HALF dspif = ~dspif;

	// core model
	// done a fixed time after reset release, idle a fixed time into reset
	always @(negedge dspif) begin
		if (proc_reset) begin
			run_cyc  = 0;
			idle_cyc = idle_cyc + 1;
		end else begin
			run_cyc  = run_cyc + 1;
			idle_cyc = 0;
		end
		core_done = !proc_reset && run_cyc == CORE_WAIT;
		elem_idle = proc_reset && idle_cyc >= ELEM_WAIT;
	end

	task automatic check_val(input string name, input longint expected, input longint actual);
		n_checks++;
		if (expected !== actual) begin
			n_errors++;
			$display("MISMATCH time %0t %s expected %0d actual %0d",
				$time, name, expected, actual);
		end
	endtask

	// sum of one window as the channel sees it, zero source gives 0
	function automatic longint window_sum(input int r, input int ch);
		longint s;
		s = 0;
		if (rec_val[r][1 + ch] != 3) begin
			for (int k = 0; k < 4; k++) begin
				s = s + rec_val[r][5 + 4 * ch + k];
			end
		end
		return s;
	endfunction

	// random on every source, then record value on lane 0 or adc
	task automatic drive_sources(input int r, input int k, input logic [NCHAN-1:0] want);
		int v;
		adc  = SAMPLE_W'($random(seed));
		dac0 = {$random(seed), $random(seed)};
		dac1 = {$random(seed), $random(seed)};
		for (int ch = 0; ch < NCHAN; ch++) begin
			v = rec_val[r][5 + 4 * ch + k];
			if (want[ch]) begin
				case (rec_val[r][1 + ch])
					0: adc = SAMPLE_W'(v);
					1: dac0[SAMPLE_W-1:0] = SAMPLE_W'(v);
					2: dac1[SAMPLE_W-1:0] = SAMPLE_W'(v);
					default: ;
				endcase
			end
		end
	endtask

	task automatic apply_reset();
		rst_n = 1'b0;
		repeat (2) @(negedge dspif);
		rst_n = 1'b1;
		for (int ch = 0; ch < NCHAN; ch++) begin
			exp_addr[ch] = 0;
		end
	endtask

	task automatic pulse_clear();
		@(negedge dspif);
		acc_clear = 1'b1;
		@(negedge dspif);
		acc_clear = 1'b0;
		for (int ch = 0; ch < NCHAN; ch++) begin
			check_val($sformatf("buf_addr[%0d]", ch), 0, longint'(buf_addr[ch]));
			exp_addr[ch] = 0;
		end
	endtask

	task automatic load_tests();
		int    fd;
		int    code;
		string line;
		n_rec = 0;
		fd    = $fopen("tb/dsp_readout_tests.txt", "r");
		if (fd == 0) begin
			n_errors++;
			$display("cannot open the test record file tb/dsp_readout_tests.txt");
		end else begin
			while (!$feof(fd) && n_rec < MAX_REC) begin
				code = $fgets(line, fd);
				// comment and blank lines hold no record
				if (code > 0 && (line[0] == "W" || line[0] == "C" || line[0] == "S")) begin
					rec_kind[n_rec] = line[0];
					for (int f = 0; f < NFIELD; f++) begin
						rec_val[n_rec][f] = 0;
					end
					code = $sscanf(line.substr(1, line.len() - 1),
						"%d %d %d %d %d %d %d %d %d %d %d %d %d %d %d",
						rec_val[n_rec][0], rec_val[n_rec][1], rec_val[n_rec][2],
						rec_val[n_rec][3], rec_val[n_rec][4], rec_val[n_rec][5],
						rec_val[n_rec][6], rec_val[n_rec][7], rec_val[n_rec][8],
						rec_val[n_rec][9], rec_val[n_rec][10], rec_val[n_rec][11],
						rec_val[n_rec][12], rec_val[n_rec][13], rec_val[n_rec][14]);
					n_rec++;
				end
			end
			$fclose(fd);
		end
		loaded = 1'b1;
	endtask

	// gate windows of one record, then result, address and sign checks
	task automatic readout_windows(input int r);
		logic [NCHAN-1:0] want;
		longint           model [NCHAN];
		int               waited;
		want  = NCHAN'(rec_val[r][0]);
		shift = SHIFT_W'(rec_val[r][3]);
		for (int ch = 0; ch < NCHAN; ch++) begin
			src_sel[ch] = src_sel_t'(rec_val[r][1 + ch][1:0]);
			model[ch]   = window_sum(r, ch) >>> rec_val[r][3];
			// file value has to agree with the model
			if (want[ch]) begin
				check_val($sformatf("record %0d expected ch%0d", r, ch),
					model[ch], longint'(rec_val[r][13 + ch]));
			end
		end
		repeat (rec_val[r][4]) begin
			for (int k = 0; k < 4; k++) begin
				@(negedge dspif);
				drive_sources(r, k, want);
				gate = want;
			end
			@(negedge dspif);
			drive_sources(r, 0, '0);
			gate   = '0;
			waited = 0;
			while (buf_we == '0 && waited < 8) begin
				@(negedge dspif);
				waited++;
			end
			if (buf_we == '0) begin
				n_errors++;
				$display("no buffer write within 8 cycles of gate close, record %0d", r);
			end else begin
				check_val("write latency", 3, longint'(waited));
				check_val("buf_we", longint'(want), longint'(buf_we));
				for (int ch = 0; ch < NCHAN; ch++) begin
					if (want[ch]) begin
						check_val($sformatf("buf_data[%0d]", ch), model[ch],
							longint'(buf_data[ch]));
						check_val($sformatf("buf_addr[%0d]", ch), longint'(exp_addr[ch]),
							longint'(buf_addr[ch]));
						// address holds at the last entry
						if (exp_addr[ch] < (1 << ADDR_W) - 1) begin
							exp_addr[ch]++;
						end
					end
				end
				@(negedge dspif);
				check_val("meas_valid", longint'(want), longint'(meas_valid));
				for (int ch = 0; ch < NCHAN; ch++) begin
					if (want[ch]) begin
						check_val($sformatf("meas[%0d]", ch), longint'(model[ch] < 0),
							longint'(meas[ch]));
					end
				end
			end
		end
	endtask

	// one sequencer run, counting core releases and last-shot strobes
	task automatic shot_sequence(input int r);
		int   releases;
		int   last_seen;
		int   tail;
		logic prev_reset;
		releases   = 0;
		last_seen  = 0;
		tail       = 0;
		prev_reset = 1'b1;
		@(negedge dspif);
		nshot     = SHOT_W'(rec_val[r][0]);
		stb_start = 1'b1;
		@(negedge dspif);
		stb_start = 0;
		// finite run watched 10 cycles past its strobe
		// endless run until the shot after the target count starts
		while (tail < 10 && !(rec_val[r][0] == 0 && releases > rec_val[r][1])) begin
			if (prev_reset && !proc_reset) begin
				releases++;
				// completed shots at each shot start
				check_val("shot_cnt", longint'(releases - 1), longint'(shot_cnt));
			end
			prev_reset = proc_reset;
			if (last_shot_done) begin
				last_seen++;
			end
			if (last_seen > 0) begin
				tail++;
			end
			@(negedge dspif);
		end
		check_val("shot_cnt", longint'(rec_val[r][1]), longint'(shot_cnt));
		if (rec_val[r][0] == 0) begin
			check_val("last_shot_done count", 0, longint'(last_seen));
			// only a reset stops an endless run
			apply_reset();
		end else begin
			check_val("last_shot_done count", 1, longint'(last_seen));
			check_val("proc_reset releases", longint'(rec_val[r][0]), longint'(releases));
			check_val("proc_done", 1, longint'(proc_done));
		end
	endtask

	initial begin
		dspif     = 1'b0;
		rst_n     = 1'b0;
		adc       = '0;
		dac0      = '0;
		dac1      = '0;
		gate      = '0;
		shift     = '0;
		acc_clear = 1'b0;
		stb_start = 1'b0;
		nshot     = '0;
		core_done = 1'b0;
		elem_idle = 1'b0;
		run_cyc   = 0;
		idle_cyc  = 0;
		n_checks  = 0;
		n_errors  = 0;
		for (int ch = 0; ch < NCHAN; ch++) begin
			src_sel[ch] = SRC_ZERO;
		end
		load_tests();
		if (n_rec == 0) begin
			n_errors++;
			$display("no test records were loaded");
		end
		apply_reset();
		for (int r = 0; r < n_rec; r++) begin
			case (rec_kind[r])
				"C": pulse_clear();
				"W": readout_windows(r);
				"S": shot_sequence(r);
				default: ;
			endcase
		end
		repeat (4) @(negedge dspif);
		$display("checks %0d, errors %0d", n_checks, n_errors);
		if (n_errors == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

	// watchdog, sized from the record count
	initial begin
		wait (loaded);
		#((n_rec + 1) * REC_BUDGET * 2 * CLK_HALF);
		$display("watchdog timeout, run exceeded its cycle budget, checks %0d, errors %0d",
			n_checks, n_errors);
		$display("*** TEST FAILED ***");
		$finish;
	end

endmodule
